//--- list.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx_dispatch.sv
logic/uart_tx.sv
logic/uart_done_collect.sv
logic/uart_tx_bank.sv
verif/uart_tx_bank_assert.sv
verif/uart_tx_bank_checker.sv
verif/uart_tx_bank_tb.sv

//--- verif/uart_tx_bank_tb.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_bank_tb;

    import uart_pkg::*;

    localparam int LANES        = `UART_LANES;
    localparam int FRAME_CYCLES = `UART_FRAME_BITS * `UART_CLKS_PER_BIT;
    localparam int N_RANDOM     = 24;
    localparam int N_BYTES      = N_RANDOM + 3 + LANES + 1;
    localparam int LIMIT_NS     = N_BYTES * 12 * FRAME_CYCLES * 40 * 4;

    logic      clk;
    logic      rst_n;
    logic      req;
    tx_req_t   req_data;
    logic      done_ack;
    logic      ack;
    lane_vec_t txd;
    logic      done_req;
    chan_t     done_chan;

    logic        hold_done;      // completions left to the test itself.
    int          sent_count = 0;
    int          done_count = 0;
    int          tb_errors  = 0;
    int          n_ok       = 0;
    int          n_bad      = 0;
    chan_t       done_log[$];
    int unsigned stim_state = 38;
    int unsigned resp_state = 38;

    uart_tx_bank dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .done_ack  (done_ack),
        .ack       (ack),
        .txd       (txd),
        .done_req  (done_req),
        .done_chan (done_chan)
    );

    uart_tx_bank_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_data  (req_data),
        .ack       (ack),
        .txd       (txd),
        .done_req  (done_req),
        .done_chan (done_chan)
    );

    always #20 clk = ~clk;

    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned stim_rand(input int unsigned n);
        stim_state = lcg_step(stim_state);
        return (stim_state >> 16) % n;
    endfunction

    function automatic int unsigned resp_rand(input int unsigned n);
        resp_state = lcg_step(resp_state);
        return (resp_state >> 16) % n;
    endfunction

    function automatic int total_errors();
        return tb_errors + chk0.errors + dut0.u_assert.fails;
    endfunction

    task automatic send_byte(input chan_t ch, input byte_t d);
        req_data <= {ch, d};
        req      <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
        sent_count++;
    endtask

    task automatic complete_one(input int delay);
        while (!done_req) @(posedge clk);
        done_log.push_back(done_chan);
        repeat (delay) @(posedge clk);
        done_ack <= 1'b1;
        @(posedge clk);
        while (done_req) @(posedge clk);
        done_ack <= 1'b0;
        @(posedge clk);
        done_count++;
    endtask

    task automatic wait_drained();
        while (done_count != sent_count || done_req || done_ack) @(posedge clk);
        repeat (4) @(posedge clk);
        chk0.check_drained();
    endtask

    task automatic end_test(input string name, input int err_before);
        int errs;
        errs = total_errors() - err_before;
        if (errs == 0) begin
            n_ok++;
            $display("%0t  %s: ok", $time, name);
        end else begin
            n_bad++;
            $display("%0t  %s: %0d errors", $time, name, errs);
        end
    endtask

    // host side of the completion port with a random delay before each ack
    initial begin : done_responder
        forever begin
            @(posedge clk);
            if (rst_n === 1'b1 && done_req && !hold_done) begin
                complete_one(int'(resp_rand(21)));
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("run timed out after %0d ns without finishing the tests", LIMIT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        chan_t     ch;
        byte_t     b0;
        byte_t     b1;
        byte_t     b2;
        int        gap;
        int        err0;
        int        first;
        logic      stalled;
        lane_vec_t seen_mask;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        done_ack  = 1'b0;
        hold_done = 1'b0;

        err0 = total_errors();
        repeat (2) @(posedge clk);
        if (txd !== {LANES{1'b1}}) begin
            tb_errors++;
            $display("FAIL %0t txd expected %h got %h", $time, {LANES{1'b1}}, txd);
        end
        if (ack !== 1'b0) begin
            tb_errors++;
            $display("FAIL %0t ack expected 0 got %b", $time, ack);
        end
        if (done_req !== 1'b0) begin
            tb_errors++;
            $display("FAIL %0t done_req expected 0 got %b", $time, done_req);
        end
        rst_n <= 1'b1;
        @(posedge clk);
        end_test("reset_state", err0);

        err0 = total_errors();
        for (int n = 0; n < N_RANDOM; n++) begin
            ch  = chan_t'(stim_rand(LANES));
            b0  = byte_t'(stim_rand(256));
            gap = int'(stim_rand(6));
            send_byte(ch, b0);
            repeat (gap) @(posedge clk);
        end
        wait_drained();
        end_test("random_traffic", err0);

        // burst to one lane with the completion port held busy
        err0      = total_errors();
        hold_done = 1'b1;
        ch = chan_t'(stim_rand(LANES));
        b0 = byte_t'(stim_rand(256));
        b1 = byte_t'(stim_rand(256));
        b2 = byte_t'(stim_rand(256));
        send_byte(ch, b0);
        send_byte(ch, b1);
        req_data <= {ch, b2};
        req      <= 1'b1;
        stalled = 1'b1;
        repeat (2 * FRAME_CYCLES + 20) begin
            @(posedge clk);
            if (ack) stalled = 1'b0;
        end
        if (!stalled) begin
            tb_errors++;
            $display("%0t: lane %0d took a third byte while its completion was pending",
                     $time, ch);
        end
        if (!done_req) begin
            tb_errors++;
            $display("%0t: first completion never reached the completion port", $time);
        end
        complete_one(0);
        while (!ack) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
        sent_count++;
        hold_done = 1'b0;
        wait_drained();
        end_test("back_pressure", err0);

        // first lane reported sends again and finishes while the others still wait
        err0      = total_errors();
        hold_done = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            send_byte(chan_t'(i), byte_t'(stim_rand(256)));
        end
        repeat (FRAME_CYCLES + 20) @(posedge clk);
        first = done_log.size();
        complete_one(0);
        ch = done_log[first];
        send_byte(ch, byte_t'(stim_rand(256)));
        complete_one(FRAME_CYCLES + 20);
        hold_done = 1'b0;
        wait_drained();
        seen_mask = '0;
        for (int i = first; i < done_log.size() && i < first + LANES; i++) begin
            if (seen_mask[done_log[i]]) begin
                tb_errors++;
                $display("%0t: lane %0d reported twice before all waiting lanes",
                         $time, done_log[i]);
            end
            seen_mask[done_log[i]] = 1'b1;
        end
        end_test("fairness", err0);

        $display("tests ok: %0d, tests failed: %0d", n_ok, n_bad);
        if (n_bad == 0 && total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/uart_tx_bank_checker.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_bank_checker (
    input logic                clk,
    input logic                rst_n,
    input uart_pkg::tx_req_t   req_data,
    input logic                ack,
    input uart_pkg::lane_vec_t txd,
    input logic                done_req,
    input uart_pkg::chan_t     done_chan
);

    import uart_pkg::*;

    localparam int LANES        = `UART_LANES;
    localparam int CPB          = `UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = `UART_FRAME_BITS * CPB;

    byte_t     exp_q [LANES][$];   // accepted bytes per lane.
    logic      busy     [LANES];
    logic      has_exp  [LANES];
    byte_t     exp_byte [LANES];
    byte_t     got      [LANES];
    int        cnt      [LANES];   // cycle inside the frame.
    int        bad      [LANES];
    int        frames   [LANES];
    int        reported [LANES];
    lane_vec_t seen     [LANES];   // lanes reported while this one waited.
    logic      prev_ack;
    logic      prev_done_req;
    int        errors = 0;

    // sampled on the falling edge half a cycle after the DUT moves
    always @(negedge clk) begin : monitor
        logic [`UART_FRAME_BITS-1:0] fr;
        int k;
        chan_t c;
        if (!rst_n) begin
            for (int i = 0; i < LANES; i++) begin
                exp_q[i].delete();
                busy[i]     = 1'b0;
                frames[i]   = 0;
                reported[i] = 0;
                seen[i]     = '0;
            end
            prev_ack      = 1'b0;
            prev_done_req = 1'b0;
        end else begin
            if (ack && !prev_ack) begin
                exp_q[req_data.chan].push_back(req_data.data);
            end
            for (int i = 0; i < LANES; i++) begin
                if (!busy[i] && !txd[i]) begin
                    busy[i]    = 1'b1;      // start bit seen.
                    cnt[i]     = 0;
                    bad[i]     = 0;
                    got[i]     = '0;
                    has_exp[i] = (exp_q[i].size() != 0);
                    if (has_exp[i]) begin
                        exp_byte[i] = exp_q[i].pop_front();
                    end else begin
                        errors++;
                        $display("%0t: lane %0d started a frame with no accepted byte",
                                 $time, i);
                    end
                end
                if (busy[i]) begin
                    k  = cnt[i] / CPB;
                    fr = {1'b1, exp_byte[i], 1'b0};
                    if (has_exp[i] && (txd[i] !== fr[k])) begin
                        bad[i]++;
                    end
                    if ((cnt[i] % CPB) == (CPB / 2) && k >= 1 && k <= 8) begin
                        got[i][k-1] = txd[i];   // mid-bit sample.
                    end
                    if (cnt[i] == FRAME_CYCLES - 1) begin
                        busy[i] = 1'b0;
                        frames[i]++;
                        if (has_exp[i] && (got[i] !== exp_byte[i] || bad[i] != 0)) begin
                            errors++;
                            $display("FAIL %0t txd[%0d] expected %02h got %02h, %0d cycles off",
                                     $time, i, exp_byte[i], got[i], bad[i]);
                        end
                    end else begin
                        cnt[i]++;
                    end
                end
            end
            if (done_req && !prev_done_req) begin
                c = done_chan;
                if (reported[c] >= frames[c]) begin
                    errors++;
                    $display("%0t: completion for lane %0d came before its frame ended",
                             $time, c);
                end else begin
                    reported[c]++;
                end
                for (int j = 0; j < LANES; j++) begin
                    if (j != int'(c) && frames[j] > reported[j]) begin
                        if (seen[j][c]) begin
                            errors++;
                            $display("%0t: lane %0d reported twice while lane %0d waited",
                                     $time, c, j);
                        end
                        seen[j][c] = 1'b1;
                    end
                end
                seen[c] = '0;
            end
            prev_ack      = ack;
            prev_done_req = done_req;
        end
    end

    task automatic check_drained();
        for (int i = 0; i < LANES; i++) begin
            if (exp_q[i].size() != 0 || busy[i]) begin
                errors++;
                $display("%0t: lane %0d still holds %0d unsent bytes",
                         $time, i, exp_q[i].size() + int'(busy[i]));
            end
            if (frames[i] != reported[i]) begin
                errors++;
                $display("%0t: lane %0d sent %0d frames but %0d completions were reported",
                         $time, i, frames[i], reported[i]);
            end
        end
    endtask

endmodule

//--- verif/uart_tx_bank_assert.sv
`timescale 1ns/1ps

module uart_tx_bank_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                req,
    input uart_pkg::tx_req_t   req_data,
    input logic                ack,
    input uart_pkg::lane_vec_t txd,
    input logic                done_req,
    input uart_pkg::chan_t     done_chan,
    input logic                done_ack
);

    int fails = 0;

    a_reset_values: assert property (@(posedge clk)
        $rose(rst_n) |-> (!ack && !done_req && (txd == '1)))
        else begin
            fails++;
            $error("outputs were not at their reset values when reset was released");
        end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else begin
            fails++;
            $error("ack rose without a pending request");
        end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack) |=> (req && $stable(req_data)))
        else begin
            fails++;
            $error("request dropped or changed before it was acknowledged");
        end

    a_done_chan_stable: assert property (@(posedge clk) disable iff (!rst_n)
        done_req |=> (!done_req || $stable(done_chan)))
        else begin
            fails++;
            $error("done_chan changed while done_req was high");
        end

    a_done_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done_ack) |-> done_req)
        else begin
            fails++;
            $error("done_ack rose without a pending completion");
        end

endmodule

bind uart_tx_bank uart_tx_bank_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_data  (req_data),
    .ack       (ack),
    .txd       (txd),
    .done_req  (done_req),
    .done_chan (done_chan),
    .done_ack  (done_ack)
);

//--- logic/uart_tx_bank.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_bank (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  uart_pkg::tx_req_t   req_data,
    input  logic                done_ack,
    output logic                ack,
    output uart_pkg::lane_vec_t txd,
    output logic                done_req,
    output uart_pkg::chan_t     done_chan
);

    import uart_pkg::*;

    lane_vec_t load;
    byte_t     load_data;   // shared by all lanes.
    lane_vec_t lane_idle;
    lane_vec_t lane_done;
    lane_vec_t done_take;

    uart_tx_dispatch u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .lane_idle (lane_idle),
        .ack       (ack),
        .load      (load),
        .load_data (load_data)
    );

    for (genvar i = 0; i < `UART_LANES; i++) begin : g_lane
        uart_tx u_tx (
            .clk       (clk),
            .rst_n     (rst_n),
            .load      (load[i]),
            .load_data (load_data),
            .done_take (done_take[i]),
            .idle      (lane_idle[i]),
            .done      (lane_done[i]),
            .txd       (txd[i])
        );
    end

    uart_done_collect u_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .lane_done (lane_done),
        .done_ack  (done_ack),
        .done_take (done_take),
        .done_req  (done_req),
        .done_chan (done_chan)
    );

endmodule

//--- logic/uart_done_collect.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_done_collect (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::lane_vec_t lane_done,
    input  logic                done_ack,
    output uart_pkg::lane_vec_t done_take,
    output logic                done_req,
    output uart_pkg::chan_t     done_chan
);

    import uart_pkg::*;

    hs_state_t state;
    chan_t     last;       // lane granted most recently.
    chan_t     pick;
    logic      found;

    // round-robin search starting just after the last grant
    always_comb begin
        int idx;
        pick  = last;
        found = 1'b0;
        for (int i = 1; i <= `UART_LANES; i++) begin
            idx = (int'(last) + i) % `UART_LANES;
            if (!found && lane_done[idx]) begin
                found = 1'b1;
                pick  = chan_t'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= HS_IDLE;
            done_take <= '0;
            done_req  <= 1'b0;
            last      <= chan_t'(`UART_LANES - 1);  // first search starts at lane 0.
        end else begin
            case (state)
                HS_IDLE: begin
                    if (found) begin
                        done_take <= lane_vec_t'(1) << pick;
                        last      <= pick;
                        state     <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    done_take <= '0;
                    if (!done_req) begin
                        done_req <= 1'b1;
                    end else if (done_ack) begin
                        done_req <= 1'b0;
                        state    <= HS_WAIT_DROP;
                    end
                end
                HS_WAIT_DROP: begin
                    if (!done_ack) begin
                        state <= HS_IDLE;    // port free again.
                    end
                end
                default: begin
                    done_take <= '0;
                    done_req  <= 1'b0;
                    state     <= HS_IDLE;
                end
            endcase
        end
    end

    // last only moves on a grant, so it is stable under done_req
    assign done_chan = last;

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  uart_pkg::byte_t load_data,
    input  logic            done_take,
    output logic            idle,
    output logic            done,
    output logic            txd
);

    import uart_pkg::*;

    localparam int BIT_IDX_W = $clog2(`UART_FRAME_BITS);

    lane_state_t                state;
    bitcnt_t                    clk_cnt;   // position inside one bit.
    logic [BIT_IDX_W-1:0]       bit_idx;   // bit of the frame on the line.
    logic [`UART_FRAME_BITS-1:0] frame;
    logic                       start;
    logic                       bit_end;
    logic                       frame_end;

    assign start     = (state == LANE_IDLE) && load;
    assign bit_end   = (state == LANE_SEND) &&
                       (clk_cnt == bitcnt_t'(`UART_CLKS_PER_BIT - 1));
    assign frame_end = bit_end && (bit_idx == BIT_IDX_W'(`UART_FRAME_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= LANE_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;                 // line idles high.
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (load) begin
                        state   <= LANE_SEND;
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        txd     <= 1'b0;     // start bit.
                    end
                end
                LANE_SEND: begin
                    if (frame_end) begin
                        // stop bit stays on the line
                        clk_cnt <= '0;
                        state   <= LANE_DONE;
                    end else if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        txd     <= frame[1];
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                LANE_DONE: begin
                    if (done_take) begin
                        state <= LANE_IDLE;  // completion reported.
                    end
                end
                default: begin
                    state <= LANE_IDLE;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

    // frame is stop, data, start; bit 0 is on the line
    always_ff @(posedge clk) begin
        if (start) begin
            frame <= {1'b1, load_data, 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[`UART_FRAME_BITS-1:1]};
        end
    end

    assign idle = (state == LANE_IDLE);
    assign done = (state == LANE_DONE);

endmodule

//--- logic/uart_tx_dispatch.sv
`timescale 1ns/1ps

module uart_tx_dispatch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  uart_pkg::tx_req_t  req_data,
    input  uart_pkg::lane_vec_t lane_idle,
    output logic               ack,
    output uart_pkg::lane_vec_t load,
    output uart_pkg::byte_t    load_data
);

    import uart_pkg::*;

    hs_state_t state;
    lane_vec_t sel;        // addressed lane, one-hot.
    logic      sel_idle;
    logic      accept;

    // decode the channel here so the lanes only see a load strobe
    assign sel      = lane_vec_t'(1) << req_data.chan;
    assign sel_idle = |(sel & lane_idle);
    assign accept   = req && sel_idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HS_IDLE;
            ack   <= 1'b0;
            load  <= '0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (accept) begin
                        load  <= sel;          // one-cycle strobe.
                        state <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    load  <= '0;
                    ack   <= 1'b1;             // byte is in the lane by now.
                    state <= HS_WAIT_DROP;
                end
                HS_WAIT_DROP: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= HS_IDLE;
                    end
                end
                default: begin
                    load  <= '0;
                    ack   <= 1'b0;
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    // payload follows the strobe.
    always_ff @(posedge clk) begin
        if (state == HS_IDLE && accept) begin
            load_data <= req_data.data;
        end
    end

endmodule

//--- logic/uart_pkg.sv
`include "uart_cfg.svh"

package uart_pkg;

    typedef logic [`UART_CHAN_W-1:0]   chan_t;     // lane number.
    typedef logic [7:0]                byte_t;
    typedef logic [`UART_BITCNT_W-1:0] bitcnt_t;   // clocks within one bit.
    typedef logic [`UART_LANES-1:0]    lane_vec_t; // one bit per lane.

    typedef struct packed {
        chan_t chan;
        byte_t data;
    } tx_req_t;

    // shared by the request and the completion port.
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_WAIT_DROP
    } hs_state_t;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_SEND,
        LANE_DONE
    } lane_state_t;

endpackage

//--- logic/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// number of transmitter lanes in the bank.
`define UART_LANES 4

// clock cycles per serial bit.
// 8 keeps simulation short; 2604 gives 19200 baud from a 50 MHz clock.
`define UART_CLKS_PER_BIT 8

// 8N1 frame is start, eight data bits and stop.
`define UART_FRAME_BITS 10

// channel number width is ceil(log2(lanes)) and at least one bit.
`define UART_CHAN_W ((`UART_LANES > 1) ? $clog2(`UART_LANES) : 1)

// bit-time counter width.
`define UART_BITCNT_W 16

`endif
